/* logic/core_cfg_pkg.sv */
`default_nettype none

package core_cfg_pkg;

    // Datapath and register file geometry
    localparam int DATA_WIDTH     = 32;
    localparam int GPR_NUM        = 32;
    localparam int GPR_ADDR_WIDTH = $clog2(GPR_NUM);
    localparam int CSR_ADDR_WIDTH = 14;

    // Implemented CSR numbers
    localparam logic [CSR_ADDR_WIDTH-1:0] CSR_CRMD  = 14'h0000;
    localparam logic [CSR_ADDR_WIDTH-1:0] CSR_PRMD  = 14'h0001;
    localparam logic [CSR_ADDR_WIDTH-1:0] CSR_ERA   = 14'h0006;
    localparam logic [CSR_ADDR_WIDTH-1:0] CSR_SAVE0 = 14'h0030;

    // PLV 0 with direct address translation enabled
    localparam logic [DATA_WIDTH-1:0] CRMD_RESET = 32'h0000_0008;
    localparam logic [1:0]            PLV_USER   = 2'd3;

endpackage

`default_nettype wire

/* logic/core_isa_pkg.sv */
`default_nettype none

package core_isa_pkg;

    // Major opcode of the CSR class, bits 31..24
    localparam logic [7:0] OP_CSR = 8'h04;

    // rj selects the CSR sub-operation, anything else is exchange
    localparam logic [4:0] CSR_RJ_RD = 5'd0;
    localparam logic [4:0] CSR_RJ_WR = 5'd1;

    // Three-register opcodes, bits 31..15
    localparam logic [16:0] OP3R_ADD = 17'h00020;
    localparam logic [16:0] OP3R_SUB = 17'h00022;
    localparam logic [16:0] OP3R_AND = 17'h00029;
    localparam logic [16:0] OP3R_OR  = 17'h0002a;

    // addi.w opcode, bits 31..22
    localparam logic [9:0] OP_ADDI = 10'h00a;

    typedef enum logic [7:0] {
        ALU_NOP,
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_CSRRD,
        ALU_CSRWR,
        ALU_CSRXCHG
    } alu_op_e;

    typedef enum logic [2:0] {
        SEL_NONE,
        SEL_ARITH,
        SEL_LOGIC,
        SEL_CSR
    } alu_sel_e;

    typedef struct packed {
        logic is_pri;
        logic is_csr;
    } special_info_t;

    typedef struct packed {
        logic [7:0]  opcode;
        logic [13:0] csr_num;
        logic [4:0]  rj;
        logic [4:0]  rd;
    } csr_fmt_t;

    // addi.w si12 sits in opcode[6:0] and rk
    typedef struct packed {
        logic [16:0] opcode;
        logic [4:0]  rk;
        logic [4:0]  rj;
        logic [4:0]  rd;
    } reg_fmt_t;

    typedef union packed {
        csr_fmt_t csr_fmt;
        reg_fmt_t reg_fmt;
    } instr_u;

endpackage

`default_nettype wire

/* logic/decode_if.sv */
`timescale 1ns/10ps
`default_nettype none

interface decode_if
    import core_cfg_pkg::*;
    import core_isa_pkg::*;
();

    logic                          valid;
    // Bit 0 is port 0, bit 1 is port 1
    logic [1:0]                    reg_read_valid;
    logic [2*GPR_ADDR_WIDTH-1:0]   reg_read_addr;
    logic                          use_imm;
    logic [DATA_WIDTH-1:0]         imm;
    logic                          reg_write_valid;
    logic [GPR_ADDR_WIDTH-1:0]     reg_write_addr;
    alu_op_e                       aluop;
    alu_sel_e                      alusel;
    logic                          kernel_instr;
    special_info_t                 special_info;

    modport source (
        output valid, reg_read_valid, reg_read_addr, use_imm, imm,
        output reg_write_valid, reg_write_addr, aluop, alusel,
        output kernel_instr, special_info
    );

    modport sink (
        input valid, reg_read_valid, reg_read_addr, use_imm, imm,
        input reg_write_valid, reg_write_addr, aluop, alusel,
        input kernel_instr, special_info
    );

endinterface

`default_nettype wire

/* logic/decoder_csr.sv */
`timescale 1ns/10ps
`default_nettype none

module decoder_csr
    import core_cfg_pkg::*;
    import core_isa_pkg::*;
(
    input  instr_u          instr_i,
    decode_if.source        dec_o
);

    logic [4:0]                rd;
    logic [4:0]                rj;
    logic [CSR_ADDR_WIDTH-1:0] csr_num;

    assign rd      = instr_i.csr_fmt.rd;
    assign rj      = instr_i.csr_fmt.rj;
    assign csr_num = instr_i.csr_fmt.csr_num;

    always_comb begin
        // Everything zero unless the word is a CSR instruction
        dec_o.valid           = 1'b0;
        dec_o.reg_read_valid  = 2'b00;
        dec_o.reg_read_addr   = '0;
        dec_o.use_imm         = 1'b0;
        dec_o.imm             = '0;
        dec_o.reg_write_valid = 1'b0;
        dec_o.reg_write_addr  = '0;
        dec_o.aluop           = ALU_NOP;
        dec_o.alusel          = SEL_NONE;
        dec_o.kernel_instr    = 1'b0;
        dec_o.special_info    = '0;

        if (instr_i.csr_fmt.opcode == OP_CSR) begin
            dec_o.valid               = 1'b1;
            dec_o.reg_write_valid     = 1'b1;
            dec_o.reg_write_addr      = rd;
            dec_o.imm                 = {{(DATA_WIDTH-CSR_ADDR_WIDTH){1'b0}}, csr_num};
            dec_o.alusel              = SEL_CSR;
            dec_o.kernel_instr        = 1'b1;
            dec_o.special_info.is_pri = 1'b1;
            dec_o.special_info.is_csr = 1'b1;

            case (rj)
                CSR_RJ_RD: begin
                    dec_o.aluop = ALU_CSRRD;
                end
                CSR_RJ_WR: begin
                    // Old rd value becomes the new CSR value
                    dec_o.aluop          = ALU_CSRWR;
                    dec_o.reg_read_valid = 2'b01;
                    dec_o.reg_read_addr  = {5'b0, rd};
                end
                default: begin
                    // rj names the mask register
                    dec_o.aluop          = ALU_CSRXCHG;
                    dec_o.reg_read_valid = 2'b11;
                    dec_o.reg_read_addr  = {rj, rd};
                end
            endcase
        end
    end

endmodule

`default_nettype wire

/* logic/decoder_alu.sv */
`timescale 1ns/10ps
`default_nettype none

module decoder_alu
    import core_cfg_pkg::*;
    import core_isa_pkg::*;
(
    input  instr_u          instr_i,
    decode_if.source        dec_o
);

    logic [16:0] op17;
    logic [11:0] si12;

    assign op17 = instr_i.reg_fmt.opcode;
    assign si12 = {instr_i.reg_fmt.opcode[6:0], instr_i.reg_fmt.rk};

    always_comb begin
        dec_o.valid           = 1'b0;
        dec_o.reg_read_valid  = 2'b00;
        dec_o.reg_read_addr   = '0;
        dec_o.use_imm         = 1'b0;
        dec_o.imm             = '0;
        dec_o.reg_write_valid = 1'b0;
        dec_o.reg_write_addr  = '0;
        dec_o.aluop           = ALU_NOP;
        dec_o.alusel          = SEL_NONE;
        dec_o.kernel_instr    = 1'b0;
        dec_o.special_info    = '0;

        if (op17 inside {OP3R_ADD, OP3R_SUB, OP3R_AND, OP3R_OR}) begin
            // rj on port 0, rk on port 1
            dec_o.valid           = 1'b1;
            dec_o.reg_read_valid  = 2'b11;
            dec_o.reg_read_addr   = {instr_i.reg_fmt.rk, instr_i.reg_fmt.rj};
            dec_o.reg_write_valid = 1'b1;
            dec_o.reg_write_addr  = instr_i.reg_fmt.rd;
            case (op17)
                OP3R_ADD: dec_o.aluop = ALU_ADD;
                OP3R_SUB: dec_o.aluop = ALU_SUB;
                OP3R_AND: dec_o.aluop = ALU_AND;
                default:  dec_o.aluop = ALU_OR;
            endcase
            if (op17 inside {OP3R_ADD, OP3R_SUB}) begin
                dec_o.alusel = SEL_ARITH;
            end else begin
                dec_o.alusel = SEL_LOGIC;
            end
        end else if (op17[16:7] == OP_ADDI) begin
            dec_o.valid           = 1'b1;
            dec_o.reg_read_valid  = 2'b01;
            dec_o.reg_read_addr   = {{GPR_ADDR_WIDTH{1'b0}}, instr_i.reg_fmt.rj};
            dec_o.use_imm         = 1'b1;
            dec_o.imm             = {{(DATA_WIDTH-12){si12[11]}}, si12};
            dec_o.reg_write_valid = 1'b1;
            dec_o.reg_write_addr  = instr_i.reg_fmt.rd;
            dec_o.aluop           = ALU_ADD;
            dec_o.alusel          = SEL_ARITH;
        end
    end

endmodule

`default_nettype wire

/* logic/decode_arbiter.sv */
`timescale 1ns/10ps
`default_nettype none

module decode_arbiter (
    decode_if.sink    csr_i,
    decode_if.sink    alu_i,
    decode_if.source  bus_o,
    output logic      illegal_o
);

    // Fixed priority, CSR first; an invalid peer drives all zeros
    always_comb begin
        if (csr_i.valid) begin
            bus_o.valid           = csr_i.valid;
            bus_o.reg_read_valid  = csr_i.reg_read_valid;
            bus_o.reg_read_addr   = csr_i.reg_read_addr;
            bus_o.use_imm         = csr_i.use_imm;
            bus_o.imm             = csr_i.imm;
            bus_o.reg_write_valid = csr_i.reg_write_valid;
            bus_o.reg_write_addr  = csr_i.reg_write_addr;
            bus_o.aluop           = csr_i.aluop;
            bus_o.alusel          = csr_i.alusel;
            bus_o.kernel_instr    = csr_i.kernel_instr;
            bus_o.special_info    = csr_i.special_info;
        end else begin
            bus_o.valid           = alu_i.valid;
            bus_o.reg_read_valid  = alu_i.reg_read_valid;
            bus_o.reg_read_addr   = alu_i.reg_read_addr;
            bus_o.use_imm         = alu_i.use_imm;
            bus_o.imm             = alu_i.imm;
            bus_o.reg_write_valid = alu_i.reg_write_valid;
            bus_o.reg_write_addr  = alu_i.reg_write_addr;
            bus_o.aluop           = alu_i.aluop;
            bus_o.alusel          = alu_i.alusel;
            bus_o.kernel_instr    = alu_i.kernel_instr;
            bus_o.special_info    = alu_i.special_info;
        end
    end

    assign illegal_o = !csr_i.valid && !alu_i.valid;

    // Opcode spaces of the two decoders must not overlap
    always_comb begin
        a_one_hot_decode: assert final (!(csr_i.valid && alu_i.valid));
    end

endmodule

`default_nettype wire

/* logic/csr_file.sv */
`timescale 1ns/10ps
`default_nettype none

module csr_file
    import core_cfg_pkg::*;
    import core_isa_pkg::*;
(
    input  logic                      clk,
    input  logic                      rst_n_i,
    input  logic                      csr_en_i,
    input  alu_op_e                   csr_op_i,
    input  logic [CSR_ADDR_WIDTH-1:0] csr_num_i,
    input  logic [DATA_WIDTH-1:0]     csr_wdata_i,
    input  logic [DATA_WIDTH-1:0]     csr_mask_i,
    output logic [DATA_WIDTH-1:0]     csr_rdata_o,
    output logic [1:0]                plv_o
);

    logic [DATA_WIDTH-1:0] crmd_q;
    logic [DATA_WIDTH-1:0] prmd_q;
    logic [DATA_WIDTH-1:0] era_q;
    logic [DATA_WIDTH-1:0] save0_q;
    logic [DATA_WIDTH-1:0] new_val;
    logic                  wr_en;

    // Unimplemented numbers read as zero
    always_comb begin
        case (csr_num_i)
            CSR_CRMD:  csr_rdata_o = crmd_q;
            CSR_PRMD:  csr_rdata_o = prmd_q;
            CSR_ERA:   csr_rdata_o = era_q;
            CSR_SAVE0: csr_rdata_o = save0_q;
            default:   csr_rdata_o = '0;
        endcase
    end

    // Exchange replaces only the masked bits
    assign new_val = (csr_op_i == ALU_CSRWR) ? csr_wdata_i :
                     ((csr_rdata_o & ~csr_mask_i) | (csr_wdata_i & csr_mask_i));
    assign wr_en   = csr_en_i && (csr_op_i != ALU_CSRRD);

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            crmd_q  <= CRMD_RESET;
            prmd_q  <= '0;
            era_q   <= '0;
            save0_q <= '0;
        end else if (wr_en) begin
            case (csr_num_i)
                CSR_CRMD:  crmd_q  <= new_val;
                CSR_PRMD:  prmd_q  <= new_val;
                CSR_ERA:   era_q   <= new_val;
                CSR_SAVE0: save0_q <= new_val;
                default: ;
            endcase
        end
    end

    assign plv_o = crmd_q[1:0];

    a_csr_op_legal: assert property (@(posedge clk) disable iff (!rst_n_i)
        csr_en_i |-> (csr_op_i inside {ALU_CSRRD, ALU_CSRWR, ALU_CSRXCHG}));

endmodule

`default_nettype wire

/* logic/exec_unit.sv */
`timescale 1ns/10ps
`default_nettype none

module exec_unit
    import core_cfg_pkg::*;
    import core_isa_pkg::*;
(
    input  logic                      clk,
    input  logic                      rst_n_i,
    input  logic                      instr_valid_i,
    decode_if.sink                    bus_i,
    input  logic                      illegal_i,
    output logic                      csr_en_o,
    output alu_op_e                   csr_op_o,
    output logic [CSR_ADDR_WIDTH-1:0] csr_num_o,
    output logic [DATA_WIDTH-1:0]     csr_wdata_o,
    output logic [DATA_WIDTH-1:0]     csr_mask_o,
    input  logic [DATA_WIDTH-1:0]     csr_rdata_i,
    input  logic [1:0]                plv_i,
    output logic                      wb_valid_o,
    output logic [GPR_ADDR_WIDTH-1:0] wb_addr_o,
    output logic [DATA_WIDTH-1:0]     wb_data_o,
    output logic                      illegal_o,
    output logic                      priv_fault_o
);

    logic [DATA_WIDTH-1:0]     gpr_q [GPR_NUM];
    logic [GPR_ADDR_WIDTH-1:0] raddr0;
    logic [GPR_ADDR_WIDTH-1:0] raddr1;
    logic [DATA_WIDTH-1:0]     rdata0;
    logic [DATA_WIDTH-1:0]     rdata1;
    logic [DATA_WIDTH-1:0]     op_b;
    logic [DATA_WIDTH-1:0]     result;
    logic                      fire;
    logic                      priv_fault;
    logic                      gpr_we;

    assign raddr0 = bus_i.reg_read_addr[GPR_ADDR_WIDTH-1:0];
    assign raddr1 = bus_i.reg_read_addr[2*GPR_ADDR_WIDTH-1:GPR_ADDR_WIDTH];
    assign rdata0 = bus_i.reg_read_valid[0] ? gpr_q[raddr0] : '0;
    assign rdata1 = bus_i.reg_read_valid[1] ? gpr_q[raddr1] : '0;
    assign op_b   = bus_i.use_imm ? bus_i.imm : rdata1;

    // Kernel-only instructions fault in user mode and change nothing
    assign fire       = instr_valid_i && bus_i.valid;
    assign priv_fault = fire && (bus_i.kernel_instr || bus_i.special_info.is_pri)
                        && (plv_i == PLV_USER);
    assign gpr_we     = fire && bus_i.reg_write_valid && !priv_fault;

    assign csr_en_o    = fire && bus_i.special_info.is_csr && !priv_fault;
    assign csr_op_o    = bus_i.aluop;
    assign csr_num_o   = bus_i.imm[CSR_ADDR_WIDTH-1:0];
    assign csr_wdata_o = rdata0;
    assign csr_mask_o  = rdata1;

    always_comb begin
        case (bus_i.alusel)
            SEL_ARITH: result = (bus_i.aluop == ALU_SUB) ? (rdata0 - op_b) : (rdata0 + op_b);
            SEL_LOGIC: result = (bus_i.aluop == ALU_AND) ? (rdata0 & op_b) : (rdata0 | op_b);
            SEL_CSR:   result = csr_rdata_i;
            default:   result = '0;
        endcase
    end

    // r0 is never written so it stays zero from reset
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            for (int i = 0; i < GPR_NUM; i++) begin
                gpr_q[i] <= '0;
            end
        end else if (gpr_we && (bus_i.reg_write_addr != '0)) begin
            gpr_q[bus_i.reg_write_addr] <= result;
        end
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            wb_valid_o   <= 1'b0;
            illegal_o    <= 1'b0;
            priv_fault_o <= 1'b0;
        end else begin
            wb_valid_o   <= gpr_we;
            illegal_o    <= instr_valid_i && illegal_i;
            priv_fault_o <= priv_fault;
        end
    end

    // Write-back payload
    always_ff @(posedge clk) begin
        wb_addr_o <= bus_i.reg_write_addr;
        wb_data_o <= result;
    end

    a_wb_not_illegal: assert property (@(posedge clk) disable iff (!rst_n_i)
        !(wb_valid_o && illegal_o));

endmodule

`default_nettype wire

/* logic/decode_exec_top.sv */
`timescale 1ns/10ps
`default_nettype none

module decode_exec_top
    import core_cfg_pkg::*;
    import core_isa_pkg::*;
(
    input  logic                      clk,
    input  logic                      rst_n_i,
    input  logic                      instr_valid_i,
    input  logic [DATA_WIDTH-1:0]     instr_i,
    output logic                      wb_valid_o,
    output logic [GPR_ADDR_WIDTH-1:0] wb_addr_o,
    output logic [DATA_WIDTH-1:0]     wb_data_o,
    output logic                      illegal_o,
    output logic                      priv_fault_o
);

    logic                      illegal;
    logic                      csr_en;
    alu_op_e                   csr_op;
    logic [CSR_ADDR_WIDTH-1:0] csr_num;
    logic [DATA_WIDTH-1:0]     csr_wdata;
    logic [DATA_WIDTH-1:0]     csr_mask;
    logic [DATA_WIDTH-1:0]     csr_rdata;
    logic [1:0]                plv;

    decode_if dec_csr ();
    decode_if dec_alu ();
    decode_if dec_bus ();

    // Peer decoders see the same word
    decoder_csr i_decoder_csr (
        .instr_i (instr_i),
        .dec_o   (dec_csr.source)
    );

    decoder_alu i_decoder_alu (
        .instr_i (instr_i),
        .dec_o   (dec_alu.source)
    );

    decode_arbiter i_decode_arbiter (
        .csr_i     (dec_csr.sink),
        .alu_i     (dec_alu.sink),
        .bus_o     (dec_bus.source),
        .illegal_o (illegal)
    );

    exec_unit i_exec_unit (
        .clk           (clk),
        .rst_n_i       (rst_n_i),
        .instr_valid_i (instr_valid_i),
        .bus_i         (dec_bus.sink),
        .illegal_i     (illegal),
        .csr_en_o      (csr_en),
        .csr_op_o      (csr_op),
        .csr_num_o     (csr_num),
        .csr_wdata_o   (csr_wdata),
        .csr_mask_o    (csr_mask),
        .csr_rdata_i   (csr_rdata),
        .plv_i         (plv),
        .wb_valid_o    (wb_valid_o),
        .wb_addr_o     (wb_addr_o),
        .wb_data_o     (wb_data_o),
        .illegal_o     (illegal_o),
        .priv_fault_o  (priv_fault_o)
    );

    csr_file i_csr_file (
        .clk         (clk),
        .rst_n_i     (rst_n_i),
        .csr_en_i    (csr_en),
        .csr_op_i    (csr_op),
        .csr_num_i   (csr_num),
        .csr_wdata_i (csr_wdata),
        .csr_mask_i  (csr_mask),
        .csr_rdata_o (csr_rdata),
        .plv_o       (plv)
    );

endmodule

`default_nettype wire

/* verif/tb_decode_exec.sv */
`timescale 1ns/10ps
`default_nettype none

module tb_decode_exec
    import core_cfg_pkg::*;
    import core_isa_pkg::*;
();

    localparam int WAIT_LIMIT = 20;
    localparam logic [13:0] CSR_UNIMPL = 14'h0002;

    logic        clk;
    logic        rst_n_i;
    logic        instr_valid_i;
    logic [31:0] instr_i;
    logic        wb_valid_o;
    logic [4:0]  wb_addr_o;
    logic [31:0] wb_data_o;
    logic        illegal_o;
    logic        priv_fault_o;

    // Reference state
    logic [31:0] gpr_model [32];
    logic [31:0] crmd_m;
    logic [31:0] prmd_m;
    logic [31:0] era_m;
    logic [31:0] save0_m;
    logic [31:0] rng_state;

    // Response captured by the issue task
    logic        resp_wb;
    logic [4:0]  resp_addr;
    logic [31:0] resp_data;
    logic        resp_illegal;
    logic        resp_fault;

    int check_count;
    int error_count;
    int test_count;

    decode_exec_top i_decode_exec_top (
        .clk           (clk),
        .rst_n_i       (rst_n_i),
        .instr_valid_i (instr_valid_i),
        .instr_i       (instr_i),
        .wb_valid_o    (wb_valid_o),
        .wb_addr_o     (wb_addr_o),
        .wb_data_o     (wb_data_o),
        .illegal_o     (illegal_o),
        .priv_fault_o  (priv_fault_o)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    function automatic logic [31:0] next_random();
        logic [31:0] x;
        x = rng_state;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        rng_state = x;
        return x;
    endfunction

    function automatic logic [31:0] encode_3r(input logic [16:0] op, input logic [4:0] rk,
                                              input logic [4:0] rj, input logic [4:0] rd);
        return {op, rk, rj, rd};
    endfunction

    function automatic logic [31:0] encode_addi(input logic [11:0] si12, input logic [4:0] rj,
                                                input logic [4:0] rd);
        return {OP_ADDI, si12, rj, rd};
    endfunction

    function automatic logic [31:0] encode_csr(input logic [13:0] num, input logic [4:0] rj,
                                               input logic [4:0] rd);
        return {OP_CSR, num, rj, rd};
    endfunction

    function automatic logic [31:0] csr_model_read(input logic [13:0] num);
        case (num)
            CSR_CRMD:  return crmd_m;
            CSR_PRMD:  return prmd_m;
            CSR_ERA:   return era_m;
            CSR_SAVE0: return save0_m;
            default:   return 32'h0;
        endcase
    endfunction

    task automatic csr_model_write(input logic [13:0] num, input logic [31:0] value);
        case (num)
            CSR_CRMD:  crmd_m = value;
            CSR_PRMD:  prmd_m = value;
            CSR_ERA:   era_m = value;
            CSR_SAVE0: save0_m = value;
            default: ;
        endcase
    endtask

    task automatic clear_models();
        for (int i = 0; i < 32; i++) begin
            gpr_model[i] = 32'h0;
        end
        crmd_m  = CRMD_RESET;
        prmd_m  = 32'h0;
        era_m   = 32'h0;
        save0_m = 32'h0;
    endtask

    task automatic apply_reset();
        @(posedge clk);
        rst_n_i <= 1'b0;
        repeat (16) @(posedge clk);
        rst_n_i <= 1'b1;
        clear_models();
    endtask

    task automatic check_hex(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
        check_count++;
        if (actual !== expected) begin
            $display("FAILED %s: expected 0x%h, actual 0x%h", name, expected, actual);
            error_count++;
        end
    endtask

    task automatic check_flag(input string name, input logic expected, input logic actual);
        check_count++;
        if (actual !== expected) begin
            $display("FAILED %s: expected 0x%h, actual 0x%h", name, expected, actual);
            error_count++;
        end
    endtask

    // One-cycle valid strobe, then wait for the registered response
    task automatic issue(input logic [31:0] word);
        int cycles;
        @(posedge clk);
        instr_i       <= word;
        instr_valid_i <= 1'b1;
        @(posedge clk);
        instr_valid_i <= 1'b0;
        cycles = 0;
        @(negedge clk);
        while (!(wb_valid_o || illegal_o || priv_fault_o) && cycles < WAIT_LIMIT) begin
            @(negedge clk);
            cycles++;
        end
        if (!(wb_valid_o || illegal_o || priv_fault_o)) begin
            $display("Timeout: no response to instruction word 0x%h", word);
            $display("CHECKS FAILED");
            $finish;
        end else begin
            resp_wb      = wb_valid_o;
            resp_addr    = wb_addr_o;
            resp_data    = wb_data_o;
            resp_illegal = illegal_o;
            resp_fault   = priv_fault_o;
        end
    endtask

    task automatic expect_writeback(input logic [4:0] rd, input logic [31:0] data);
        check_flag("wb_valid_o", 1'b1, resp_wb);
        check_flag("illegal_o", 1'b0, resp_illegal);
        check_flag("priv_fault_o", 1'b0, resp_fault);
        check_hex("wb_addr_o", 32'(rd), 32'(resp_addr));
        check_hex("wb_data_o", data, resp_data);
        // r0 stays zero
        if (rd != 5'd0) begin
            gpr_model[rd] = data;
        end
    endtask

    task automatic run_addi(input logic [11:0] si12, input logic [4:0] rj, input logic [4:0] rd);
        logic [31:0] expected;
        expected = gpr_model[rj] + {{20{si12[11]}}, si12};
        issue(encode_addi(si12, rj, rd));
        expect_writeback(rd, expected);
    endtask

    task automatic run_3r(input logic [16:0] op, input logic [4:0] rk, input logic [4:0] rj,
                          input logic [4:0] rd);
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] expected;
        a = gpr_model[rj];
        b = gpr_model[rk];
        case (op)
            OP3R_ADD: expected = a + b;
            OP3R_SUB: expected = a - b;
            OP3R_AND: expected = a & b;
            default:  expected = a | b;
        endcase
        issue(encode_3r(op, rk, rj, rd));
        expect_writeback(rd, expected);
    endtask

    // rj 0 reads, rj 1 writes, other rj exchange under the mask in rj
    task automatic run_csr(input logic [13:0] num, input logic [4:0] rj, input logic [4:0] rd);
        logic [31:0] old_val;
        logic [31:0] new_val;
        logic [31:0] mask;
        old_val = csr_model_read(num);
        if (rj == CSR_RJ_RD) begin
            new_val = old_val;
        end else if (rj == CSR_RJ_WR) begin
            new_val = gpr_model[rd];
        end else begin
            mask    = gpr_model[rj];
            new_val = (old_val & ~mask) | (gpr_model[rd] & mask);
        end
        issue(encode_csr(num, rj, rd));
        if (crmd_m[1:0] == PLV_USER) begin
            check_flag("priv_fault_o", 1'b1, resp_fault);
            check_flag("wb_valid_o", 1'b0, resp_wb);
            check_flag("illegal_o", 1'b0, resp_illegal);
        end else begin
            expect_writeback(rd, old_val);
            csr_model_write(num, new_val);
        end
    endtask

    task automatic report_test(input string name, input int errs_before);
        test_count++;
        if (error_count == errs_before) begin
            $display("test %s: ok", name);
        end else begin
            $display("test %s: %0d errors", name, error_count - errs_before);
        end
    endtask

    task automatic test_alu();
        int          errs_before;
        logic [31:0] rnd;
        errs_before = error_count;
        for (int r = 1; r <= 6; r++) begin
            rnd = next_random();
            run_addi(rnd[11:0], 5'd0, 5'(r));
        end
        run_3r(OP3R_ADD, 5'd2, 5'd1, 5'd7);
        run_3r(OP3R_SUB, 5'd4, 5'd3, 5'd8);
        run_3r(OP3R_AND, 5'd6, 5'd5, 5'd9);
        run_3r(OP3R_OR, 5'd3, 5'd1, 5'd10);
        run_3r(OP3R_SUB, 5'd7, 5'd8, 5'd11);
        // Write to r0 is reported but dropped
        run_3r(OP3R_ADD, 5'd2, 5'd1, 5'd0);
        run_3r(OP3R_OR, 5'd0, 5'd0, 5'd12);
        report_test("alu", errs_before);
    endtask

    task automatic test_csr_rw();
        int errs_before;
        errs_before = error_count;
        run_csr(CSR_CRMD, CSR_RJ_RD, 5'd13);
        run_csr(CSR_SAVE0, CSR_RJ_WR, 5'd11);
        run_csr(CSR_SAVE0, CSR_RJ_RD, 5'd14);
        report_test("csr_rw", errs_before);
    endtask

    task automatic test_csr_xchg();
        int          errs_before;
        logic [31:0] rnd;
        errs_before = error_count;
        run_csr(CSR_ERA, CSR_RJ_WR, 5'd10);
        rnd = next_random();
        run_addi(rnd[11:0], 5'd0, 5'd15);
        run_addi(rnd[23:12], 5'd8, 5'd16);
        run_csr(CSR_ERA, 5'd15, 5'd16);
        run_csr(CSR_ERA, CSR_RJ_RD, 5'd17);
        report_test("csr_xchg", errs_before);
    endtask

    task automatic test_csr_unimpl();
        int errs_before;
        errs_before = error_count;
        run_csr(CSR_UNIMPL, CSR_RJ_RD, 5'd18);
        run_csr(CSR_UNIMPL, CSR_RJ_WR, 5'd9);
        run_csr(CSR_UNIMPL, CSR_RJ_RD, 5'd18);
        report_test("csr_unimpl", errs_before);
    endtask

    task automatic test_illegal();
        int errs_before;
        errs_before = error_count;
        // Both words name r7 as rd
        issue(32'hffff_ffe7);
        check_flag("illegal_o", 1'b1, resp_illegal);
        check_flag("wb_valid_o", 1'b0, resp_wb);
        check_flag("priv_fault_o", 1'b0, resp_fault);
        issue(32'h0000_0007);
        check_flag("illegal_o", 1'b1, resp_illegal);
        check_flag("wb_valid_o", 1'b0, resp_wb);
        // Registers must be untouched
        run_3r(OP3R_OR, 5'd0, 5'd7, 5'd19);
        report_test("illegal", errs_before);
    endtask

    task automatic test_privilege();
        int errs_before;
        errs_before = error_count;
        // CRMD with PLV 3 and DA kept
        run_addi(12'h00b, 5'd0, 5'd20);
        run_csr(CSR_CRMD, CSR_RJ_WR, 5'd20);
        // r20 now holds the old CRMD, so this write would drop PLV back to 0
        run_csr(CSR_CRMD, CSR_RJ_WR, 5'd20);
        run_csr(CSR_SAVE0, CSR_RJ_WR, 5'd7);
        run_3r(OP3R_ADD, 5'd0, 5'd7, 5'd21);
        apply_reset();
        run_csr(CSR_CRMD, CSR_RJ_RD, 5'd22);
        run_csr(CSR_SAVE0, CSR_RJ_RD, 5'd23);
        report_test("privilege", errs_before);
    endtask

    initial begin
        rst_n_i       = 1'b0;
        instr_valid_i = 1'b0;
        instr_i       = 32'h0;
        rng_state     = 32'd78;
        check_count   = 0;
        error_count   = 0;
        test_count    = 0;
        apply_reset();
        test_alu();
        test_csr_rw();
        test_csr_xchg();
        test_csr_unimpl();
        test_illegal();
        test_privilege();
        $display("tests: %0d, checks: %0d, errors: %0d", test_count, check_count, error_count);
        if (error_count == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* list.f */
logic/core_cfg_pkg.sv
logic/core_isa_pkg.sv
logic/decode_if.sv
logic/decoder_csr.sv
logic/decoder_alu.sv
logic/decode_arbiter.sv
logic/csr_file.sv
logic/exec_unit.sv
logic/decode_exec_top.sv
verif/tb_decode_exec.sv

/* Makefile */
LOG = sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove build output and the log"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -f list.f --top-module tb_decode_exec -o tb_sim
	./obj_dir/tb_sim | tee $(LOG)
	grep -q "ALL CHECKS PASSED" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
